// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP      := midiVisualizer_tb
FILELIST := src.f

BUILDDIR := obj_dir
BIN      := $(BUILDDIR)/V$(TOP)
LOG      := sim.log
PASSMSG  := RESULT: PASS
SOURCES  := $(shell grep -v '^+' $(FILELIST)) include/midi_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASSMSG)' $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== dv/midiVisualizer_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module midiVisualizerProperties (
  input logic                    CLOCK_50,
  input logic                    rstN,
  input midiPkg::byteStrobe_t    rxByte,
  input midiPkg::messageStrobe_t message,
  input logic [1:0]              needCount, // Assembler internal.
  input logic                    runValid   // Assembler internal.
);

  // ==========================================================================
  // Strobes
  // ==========================================================================

  byteSinglePulse: assert property (@(posedge CLOCK_50) disable iff (!rstN)
    rxByte.valid |=> !rxByte.valid)
    else $error("Byte strobe stayed high for more than one cycle.");

  messageSinglePulse: assert property (@(posedge CLOCK_50) disable iff (!rstN)
    message.valid |=> !message.valid)
    else $error("Message strobe stayed high for more than one cycle.");

  // A system byte or the last data byte yields its message on the next cycle.
  messageFollowsByte: assert property (@(posedge CLOCK_50) disable iff (!rstN)
    rxByte.valid && (rxByte.data.status.isStatus ? rxByte.data.status.command == 3'h7
                                                 : needCount == 2'd1)
    |=> message.valid)
    else $error("Message strobe missing one cycle after a closing byte.");

  noMessageWithoutByte: assert property (@(posedge CLOCK_50) disable iff (!rstN)
    !$past(rxByte.valid) |-> !message.valid)
    else $error("Message strobe without a byte strobe one cycle earlier.");

  // Open messages only exist under a channel status.
  needOnlyWithStatus: assert property (@(posedge CLOCK_50) disable iff (!rstN)
    !runValid |-> needCount == 2'd0)
    else $error("Assembler waits for data bytes with no running status.");

endmodule

`default_nettype wire

// ==== dv/midiVisualizer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "midi_settings.svh"

module midiVisualizer_tb;

  localparam int clksPerBit = `MIDI_CLKS_PER_BIT;
  localparam int depth      = `MIDI_HISTORY_DEPTH;
  localparam int totalBytes = 81;                      // Bytes sent by all tests.
  localparam int cycleLimit = totalBytes * 12 * clksPerBit + 20000;

  logic                   CLOCK_50;
  logic                   rstN;
  logic                   serialIn;
  logic [3:0]             page;
  displayPkg::hexDigits_t digits;

  logic [31:0] refHistory [$];  // Model history with the newest first.
  logic [7:0]  refRun;          // Model running status.
  logic        refRunValid;
  int          refNeed;         // Data bytes the open message still needs.
  logic [31:0] refPartial;
  string       testName;
  int          cycleCount = 0;
  event        checkReq;
  event        checkDone;

  midiVisualizer dut_i (
    .CLOCK_50(CLOCK_50),
    .rstN(rstN),
    .serialIn(serialIn),
    .page(page),
    .digits(digits)
  );

  bind midiMessageAssembler midiVisualizerProperties props_i (
    .CLOCK_50(CLOCK_50),
    .rstN(rstN),
    .rxByte(rxByte),
    .message(message),
    .needCount(needCount),
    .runValid(runValid)
  );

  initial CLOCK_50 = 1'b0;
  always #10 CLOCK_50 = ~CLOCK_50; // 50 MHz.

  // ==========================================================================
  // Reference model
  // ==========================================================================

  // Lit segments with bit 0 as segment a. Lowercase b and d.
  function automatic logic [6:0] segmentsOn(logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h3F;
      4'h1: return 7'h06;
      4'h2: return 7'h5B;
      4'h3: return 7'h4F;
      4'h4: return 7'h66;
      4'h5: return 7'h6D;
      4'h6: return 7'h7D;
      4'h7: return 7'h07;
      4'h8: return 7'h7F;
      4'h9: return 7'h6F;
      4'hA: return 7'h77;
      4'hB: return 7'h7C;
      4'hC: return 7'h39;
      4'hD: return 7'h5E;
      4'hE: return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  // Display is active low with digit7 on the top nibble.
  function automatic displayPkg::hexDigits_t expectDigits(logic [31:0] word);
    displayPkg::hexDigits_t d;
    d.digit7 = ~segmentsOn(word[31:28]);
    d.digit6 = ~segmentsOn(word[27:24]);
    d.digit5 = ~segmentsOn(word[23:20]);
    d.digit4 = ~segmentsOn(word[19:16]);
    d.digit3 = ~segmentsOn(word[15:12]);
    d.digit2 = ~segmentsOn(word[11:8]);
    d.digit1 = ~segmentsOn(word[7:4]);
    d.digit0 = ~segmentsOn(word[3:0]);
    return d;
  endfunction

  function automatic int dataBytesNeeded(logic [7:0] status);
    return (status[7:4] == 4'hC || status[7:4] == 4'hD) ? 1 : 2;
  endfunction

  task automatic storeMessage(logic [31:0] word);
    refHistory.push_front(word);
    if (refHistory.size() > depth) void'(refHistory.pop_back()); // Oldest drops.
  endtask

  task automatic modelByte(logic [7:0] b);
    if (b >= 8'hF8) begin
      storeMessage({8'd1, b, 16'h0000}); // Real-time byte leaves the state untouched.
    end else if (b >= 8'hF0) begin
      storeMessage({8'd1, b, 16'h0000});
      refRunValid = 1'b0;
      refNeed     = 0;
    end else if (b[7]) begin
      refRun      = b;
      refRunValid = 1'b1;
      refNeed     = dataBytesNeeded(b);
      refPartial  = {8'd1, b, 16'h0000};
    end else if (refNeed > 0) begin
      if (refPartial[31:24] == 8'd1) refPartial[15:8] = b;
      else refPartial[7:0] = b;
      refPartial[31:24] = refPartial[31:24] + 8'd1;
      refNeed--;
      if (refNeed == 0) storeMessage(refPartial);
    end else if (refRunValid) begin
      refPartial = {8'd2, refRun, b, 8'h00}; // Running status reopens.
      refNeed    = dataBytesNeeded(refRun) - 1;
      if (refNeed == 0) storeMessage(refPartial);
    end
  endtask

  // ==========================================================================
  // Serial driver and checks
  // ==========================================================================

  task automatic failRun(string why);
    $display("RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  // 8N1 frame with the LSB first. lowStop forces a framing error.
  task automatic sendByte(logic [7:0] b, logic lowStop);
    logic [9:0] frame;
    frame = {~lowStop, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge CLOCK_50);
      #2;
      serialIn = frame[i];
      repeat (clksPerBit - 1) @(posedge CLOCK_50);
    end
    @(posedge CLOCK_50);
    #2;
    serialIn = 1'b1;
    repeat (clksPerBit) @(posedge CLOCK_50); // One idle bit time.
  endtask

  task automatic runCheck();
    -> checkReq;
    @(checkDone);
  endtask

  task automatic sendAndCheck(logic [7:0] b);
    sendByte(b, 1'b0);
    modelByte(b);
    runCheck();
  endtask

  // Sweeps every page and compares with the model.
  initial begin : compareProc
    displayPkg::hexDigits_t expected;
    forever begin
      @(checkReq);
      for (int p = 0; p < depth; p++) begin
        @(posedge CLOCK_50);
        #2;
        page = 4'(p);
        @(negedge CLOCK_50); // Page path is combinational.
        expected = expectDigits(refHistory[p]);
        assert (digits === expected) else begin
          $display("[ERROR] %s: page %0d expected %h actual %h",
                   testName, p, expected, digits);
          failRun("Displayed digits differ from the model.");
        end
      end
      -> checkDone;
    end
  end

  always @(posedge CLOCK_50) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles.", cycleLimit);
      failRun("Timeout.");
    end
  end

  // ==========================================================================
  // Tests
  // ==========================================================================

  initial begin
    logic [3:0] channel;
    logic [6:0] note;
    logic [6:0] velocity;
    void'($urandom(58790));
    serialIn    = 1'b1;
    page        = 4'd0;
    rstN        = 1'b0;
    refRun      = 8'h00;
    refRunValid = 1'b0;
    refNeed     = 0;
    refPartial  = 32'h0;
    for (int i = 0; i < depth; i++) refHistory.push_back(32'h0);
    repeat (3) @(posedge CLOCK_50);
    #2;
    rstN = 1'b1;

    testName = "reset";
    runCheck();

    testName = "noteOn";
    sendAndCheck(8'h93);
    sendAndCheck(8'h3C);
    sendAndCheck(8'h64);

    testName = "runningStatus";
    sendAndCheck(8'h91);
    sendAndCheck(8'h40);
    sendAndCheck(8'h50);
    sendAndCheck(8'h43); // No status byte so running status applies.
    sendAndCheck(8'h00);

    testName = "programChange";
    sendAndCheck(8'hC5);
    sendAndCheck(8'h12);

    testName = "realTimeAndSystem";
    sendAndCheck(8'h92);
    sendAndCheck(8'h30);
    sendAndCheck(8'hF8); // Timing clock inside the open message.
    sendAndCheck(8'h7F);
    sendAndCheck(8'hF0);
    sendAndCheck(8'h11); // Dropped since the status was cleared.
    sendAndCheck(8'h22); // A stale status would complete a message here.

    testName = "badStopBit";
    sendByte(8'hF8, 1'b1);
    runCheck();
    sendAndCheck(8'hB2);
    sendAndCheck(8'h07);
    sendAndCheck(8'h55);

    testName = "randomMessages";
    repeat (20) begin
      channel  = 4'($urandom);
      note     = 7'($urandom);
      velocity = 7'($urandom);
      sendAndCheck({4'h9, channel});
      sendAndCheck({1'b0, note});
      sendAndCheck({1'b0, velocity});
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== include/midi_settings.svh ====
`ifndef MIDI_SETTINGS_SVH
`define MIDI_SETTINGS_SVH

// ==========================================================================
// Serial timing
// ==========================================================================

// 50 MHz board clock over 31250 baud MIDI.
`define MIDI_CLKS_PER_BIT 1600

// ==========================================================================
// Storage and display
// ==========================================================================

`define MIDI_HISTORY_DEPTH 16 // Messages kept, one per page.

// Seven-segment digits across the board, one nibble each.
`define MIDI_HEX_DIGITS 8

`endif

// ==== src.f ====
+incdir+include
verilog/midiPkg.sv
verilog/displayPkg.sv
verilog/midiUartRx.sv
verilog/midiMessageAssembler.sv
verilog/messageHistory.sv
verilog/hexDisplay.sv
verilog/midiVisualizer.sv
dv/midiVisualizer_properties.sv
dv/midiVisualizer_tb.sv

// ==== verilog/displayPkg.sv ====
`default_nettype none

package displayPkg;

  // Active-low segments. Bit 0 is segment a, bit 6 is segment g.
  typedef logic [6:0] segments_t;

  // Eight digits, digit7 leftmost.
  // digit7 shows bits 31:28 of the word, digit0 bits 3:0.
  typedef struct packed {
    segments_t digit7; // Count, high nibble.
    segments_t digit6; // Count, low nibble.
    segments_t digit5; // Status, high nibble.
    segments_t digit4; // Status, low nibble.
    segments_t digit3; // Data1, high nibble.
    segments_t digit2; // Data1, low nibble.
    segments_t digit1; // Data2, high nibble.
    segments_t digit0; // Data2, low nibble.
  } hexDigits_t;

endpackage

`default_nettype wire

// ==== verilog/hexDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "midi_settings.svh"

module hexDisplay (
  input  midiPkg::midiMessage_t word,
  output displayPkg::hexDigits_t digits
);

  localparam int numDigits = `MIDI_HEX_DIGITS;

  logic [numDigits*4-1:0] wordBits;
  logic [numDigits*7-1:0] segBits; // Digit 0 in the low seven bits.

  // Active-low glyph, bits ordered g down to a.
  function automatic displayPkg::segments_t glyph(logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'hA:    return 7'h08;
      4'hB:    return 7'h03; // Lowercase b.
      4'hC:    return 7'h46;
      4'hD:    return 7'h21; // Lowercase d.
      4'hE:    return 7'h06;
      default: return 7'h0E; // F.
    endcase
  endfunction

  assign wordBits = word;

  always_comb begin
    for (int i = 0; i < numDigits; i++) begin
      segBits[i*7 +: 7] = glyph(wordBits[i*4 +: 4]);
    end
  end

  assign digits = segBits;

endmodule

`default_nettype wire

// ==== verilog/messageHistory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "midi_settings.svh"

module messageHistory (
  input  logic                    CLOCK_50,
  input  logic                    rstN,
  input  midiPkg::messageStrobe_t message,
  input  logic [3:0]              page,     // 0 is the newest message.
  output midiPkg::midiMessage_t   shown
);

  localparam int depth = `MIDI_HISTORY_DEPTH;

  midiPkg::midiMessage_t entries [depth];

  // ==========================================================================
  // Shift store
  // ==========================================================================

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < depth; i++) begin
        entries[i] <= '0; // Blank pages read as zeros.
      end
    end else if (message.valid) begin
      entries[0] <= message.msg;
      for (int i = 1; i < depth; i++) begin
        entries[i] <= entries[i-1]; // Oldest falls off the end.
      end
    end
  end

  // Page select, no register in the path.
  assign shown = entries[page];

endmodule

`default_nettype wire

// ==== verilog/midiMessageAssembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module midiMessageAssembler (
  input  logic                   CLOCK_50,
  input  logic                   rstN,
  input  midiPkg::byteStrobe_t   rxByte,
  output midiPkg::messageStrobe_t message
);

  midiPkg::midiByte_t    inByte;
  midiPkg::midiByte_t    dataByte;    // Incoming byte through the data view.
  midiPkg::midiByte_t    runStatus;   // Last channel status.
  logic                  runValid;
  logic [1:0]            needCount;   // Data bytes the open message still needs.
  midiPkg::midiMessage_t partial;
  midiPkg::midiByte_t    nextRunStatus;
  logic                  nextRunValid;
  logic [1:0]            nextNeed;
  midiPkg::midiMessage_t nextPartial;
  logic                  emit;
  midiPkg::midiMessage_t emitMsg;
  logic                  msgValid;
  midiPkg::midiMessage_t msgWord;

  // Data bytes that follow a status byte.
  function automatic logic [1:0] dataBytesFor(midiPkg::midiByte_t s);
    case (s.status.command)
      3'h4, 3'h5: return 2'd1; // Program change, channel pressure.
      3'h7:       return 2'd0; // System, handled on its own.
      default:    return 2'd2;
    endcase
  endfunction

  // ==========================================================================
  // Byte decode
  // ==========================================================================

  always_comb begin
    inByte              = rxByte.data;
    dataByte            = '0;
    dataByte.data.value = inByte.data.value;
    nextRunStatus       = runStatus;
    nextRunValid        = runValid;
    nextNeed            = needCount;
    nextPartial         = partial;
    emit                = 1'b0;
    emitMsg             = '0;
    if (rxByte.valid) begin
      if (inByte.status.isStatus) begin
        if (inByte.status.command == 3'h7) begin
          emit           = 1'b1; // System byte stands alone.
          emitMsg.count  = 8'd1;
          emitMsg.status = inByte;
          if (!inByte.status.channel[3]) begin
            nextRunValid = 1'b0; // 0xF0..0xF7 ends running status.
            nextNeed     = 2'd0;
          end
        end else begin
          // Channel status, drops whatever was open.
          nextRunStatus      = inByte;
          nextRunValid       = 1'b1;
          nextNeed           = dataBytesFor(inByte);
          nextPartial        = '0;
          nextPartial.count  = 8'd1;
          nextPartial.status = inByte;
        end
      end else if (needCount != 2'd0) begin
        nextPartial.count = partial.count + 8'd1;
        if (partial.count == 8'd1) nextPartial.data1 = dataByte;
        else                       nextPartial.data2 = dataByte;
        nextNeed = needCount - 2'd1;
        if (needCount == 2'd1) begin
          emit    = 1'b1;
          emitMsg = nextPartial;
        end
      end else if (runValid) begin
        // Running status opens a new message.
        nextPartial        = '0;
        nextPartial.count  = 8'd2;
        nextPartial.status = runStatus;
        nextPartial.data1  = dataByte;
        nextNeed           = dataBytesFor(runStatus) - 2'd1;
        if (dataBytesFor(runStatus) == 2'd1) begin
          emit    = 1'b1;
          emitMsg = nextPartial;
        end
      end
    end
  end

  // ==========================================================================
  // State and output
  // ==========================================================================

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      runStatus <= '0;
      runValid  <= 1'b0;
      needCount <= 2'd0;
      msgValid  <= 1'b0;
    end else begin
      runStatus <= nextRunStatus;
      runValid  <= nextRunValid;
      needCount <= nextNeed;
      msgValid  <= emit; // One cycle after the closing byte.
    end
  end

  always_ff @(posedge CLOCK_50) begin
    partial <= nextPartial;
    if (emit) msgWord <= emitMsg;
  end

  always_comb begin
    message.valid = msgValid;
    message.msg   = msgWord;
  end

endmodule

`default_nettype wire

// ==== verilog/midiPkg.sv ====
`default_nettype none

package midiPkg;

  // Status view of a byte. Command 3'h0 stands for 0x8, 3'h7 for 0xF.
  typedef struct packed {
    logic       isStatus; // Set on status bytes.
    logic [2:0] command;  // Low three bits of the high nibble.
    logic [3:0] channel;  // Channel, or system sub-code under 0xF.
  } statusView_t;

  // Data view of the same byte.
  typedef struct packed {
    logic       isStatus; // Clear on data bytes.
    logic [6:0] value;    // Note, velocity, program and so on.
  } dataView_t;

  // One received byte, read as status or data by its top bit.
  typedef union packed {
    statusView_t status;
    dataView_t   data;
  } midiByte_t;

  // Byte from the UART with its one-cycle strobe.
  typedef struct packed {
    logic      valid;
    midiByte_t data;
  } byteStrobe_t;

  // Complete message as stored and shown, count in the top byte.
  typedef struct packed {
    logic [7:0] count; // 1 plus the data bytes.
    midiByte_t  status;
    midiByte_t  data1; // Zero when unused.
    midiByte_t  data2; // Zero when unused.
  } midiMessage_t;

  typedef struct packed {
    logic         valid; // One-cycle pulse.
    midiMessage_t msg;
  } messageStrobe_t;

endpackage

`default_nettype wire

// ==== verilog/midiUartRx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "midi_settings.svh"

module midiUartRx (
  input  logic                CLOCK_50,
  input  logic                rstN,
  input  logic                serialIn, // Idle high MIDI line.
  output midiPkg::byteStrobe_t rxByte
);

  localparam int clksPerBit = `MIDI_CLKS_PER_BIT;
  localparam int halfBit    = clksPerBit / 2;
  localparam int timerW     = $clog2(clksPerBit);

  typedef enum logic [1:0] {
    rxIdle,
    rxStart,
    rxData,
    rxStop
  } rxState_t;

  rxState_t          state;
  logic              serSync1; // First synchronizer flop.
  logic              serSync2; // Safe copy of the line.
  logic              serPrev;  // For the falling edge.
  logic [timerW-1:0] bitTimer; // Cycles into the current bit.
  logic [2:0]        bitIndex;
  logic [7:0]        shiftReg;
  logic              byteValid;
  logic              halfDone;
  logic              bitDone;

  assign halfDone = (bitTimer == timerW'(halfBit - 1));
  assign bitDone  = (bitTimer == timerW'(clksPerBit - 1));

  // ==========================================================================
  // Line synchronizer
  // ==========================================================================

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      serSync1 <= 1'b1; // Line idles high.
      serSync2 <= 1'b1;
      serPrev  <= 1'b1;
    end else begin
      serSync1 <= serialIn;
      serSync2 <= serSync1;
      serPrev  <= serSync2;
    end
  end

  // ==========================================================================
  // Frame FSM
  // ==========================================================================

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      state     <= rxIdle;
      bitTimer  <= '0;
      bitIndex  <= '0;
      byteValid <= 1'b0;
    end else begin
      byteValid <= 1'b0; // Strobe lasts one cycle.
      case (state)
        rxIdle: begin
          bitTimer <= '0;
          bitIndex <= '0;
          if (serPrev && !serSync2) state <= rxStart; // Start edge.
        end
        rxStart: begin
          if (halfDone) begin
            bitTimer <= '0;
            state    <= serSync2 ? rxIdle : rxData; // Glitch goes back to idle.
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        rxData: begin
          if (bitDone) begin
            bitTimer <= '0;
            bitIndex <= bitIndex + 3'd1;
            if (bitIndex == 3'd7) state <= rxStop;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        rxStop: begin
          if (bitDone) begin
            byteValid <= serSync2; // Low stop bit drops the byte.
            state     <= rxIdle;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        default: state <= rxIdle;
      endcase
    end
  end

  // LSB first, so shift in from the top.
  always_ff @(posedge CLOCK_50) begin
    if (state == rxData && bitDone) shiftReg <= {serSync2, shiftReg[7:1]};
  end

  always_comb begin
    rxByte.valid = byteValid;
    rxByte.data  = shiftReg; // Held steady through the stop bit.
  end

endmodule

`default_nettype wire

// ==== verilog/midiVisualizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module midiVisualizer (
  input  logic                   CLOCK_50,
  input  logic                   rstN,
  input  logic                   serialIn,
  input  logic [3:0]             page,   // Board switches.
  output displayPkg::hexDigits_t digits
);

  midiPkg::byteStrobe_t    rxByte;  // Stage 1 to 2.
  midiPkg::messageStrobe_t message; // Stage 2 to 3.
  midiPkg::midiMessage_t   shown;   // Stage 3 to 4.

  // ==========================================================================
  // Pipeline
  // ==========================================================================

  midiUartRx uartRx_i (
    .CLOCK_50,
    .rstN,
    .serialIn,
    .rxByte
  );

  midiMessageAssembler assembler_i (
    .CLOCK_50,
    .rstN,
    .rxByte,
    .message
  );

  messageHistory history_i (
    .CLOCK_50,
    .rstN,
    .message,
    .page,
    .shown
  );

  // Pure decode, so page changes show at once.
  hexDisplay display_i (
    .word(shown),
    .digits
  );

endmodule

`default_nettype wire
